// File: verilog/rx_phy_pkg.sv
`default_nettype none

package rx_phy_pkg;

  // bytes carried by one symbol word from the elastic FIFO
  localparam int lane_bytes = 4;

  // 8b/10b framing codes
  // these only count when the byte's K flag is set
  // start of TLP
  localparam logic [7:0] sym_stp = 8'hFB;
  // start of DLLP
  localparam logic [7:0] sym_sdp = 8'h5C;
  // good end of packet
  localparam logic [7:0] sym_end = 8'hFD;
  // end bad, packet is nullified
  localparam logic [7:0] sym_edb = 8'hFE;

  // class of one received byte
  typedef enum logic [2:0] {
    data     = 3'd0,
    stp      = 3'd1,
    sdp      = 3'd2,
    end_good = 3'd3,
    end_edb  = 3'd4,
    // skip, comma and friends, dropped by the framer
    other_k  = 3'd5
  } byte_class_e;

  // one decoded symbol word
  // byte 0 is the first byte on the wire
  typedef struct packed {
    logic [lane_bytes-1:0][7:0] byte_data;
    byte_class_e [lane_bytes-1:0] byte_cls;
    logic valid;
  } dec_beat_t;

  // stream user field
  // nullified is only meaningful on the last beat
  typedef struct packed {
    logic nullified;
    logic tlp;
  } pkt_user_t;

  // one AXI-stream beat
  // keep is always low aligned
  typedef struct packed {
    logic [8*lane_bytes-1:0] tdata;
    logic [lane_bytes-1:0] tkeep;
    logic tlast;
    pkt_user_t tuser;
  } axis_beat_t;

endpackage

`default_nettype wire

// File: verilog/rx_symbol_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rx_symbol_decode (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  data_valid_i,
  input  logic [31:0]           data_i,
  input  logic [3:0]            data_k_i,
  output rx_phy_pkg::dec_beat_t dec_o
);

  // classes of the incoming word, before the register
  rx_phy_pkg::byte_class_e [rx_phy_pkg::lane_bytes-1:0] cls_d;

  // classify one byte from its value and K flag
  function automatic rx_phy_pkg::byte_class_e classify(
    input logic [7:0] value,
    input logic       is_k
  );
    rx_phy_pkg::byte_class_e c;
    c = rx_phy_pkg::data;
    if (is_k) begin
      case (value)
        rx_phy_pkg::sym_stp: c = rx_phy_pkg::stp;
        rx_phy_pkg::sym_sdp: c = rx_phy_pkg::sdp;
        rx_phy_pkg::sym_end: c = rx_phy_pkg::end_good;
        rx_phy_pkg::sym_edb: c = rx_phy_pkg::end_edb;
        // any other control symbol is ignored downstream
        default: c = rx_phy_pkg::other_k;
      endcase
    end
    return c;
  endfunction

  // tag every byte of the word
  always_comb begin
    for (int i = 0; i < rx_phy_pkg::lane_bytes; i++) begin
      cls_d[i] = classify(data_i[8*i +: 8], data_k_i[i]);
    end
  end

  // one cycle of latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= data_valid_i;
    end
    // data bytes in wire order, byte 0 low
    dec_o.byte_data <= data_i;
    dec_o.byte_cls  <= cls_d;
  end

endmodule

`default_nettype wire

// File: verilog/rx_frame_align.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_align (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   phy_link_up_i,
  input  logic                   phy_fifo_empty_i,
  input  rx_phy_pkg::dec_beat_t  dec_i,
  input  logic [3:0]             free_slots_i,
  output logic                   phy_fifo_rd_en_o,
  output rx_phy_pkg::axis_beat_t beat_o,
  output logic                   beat_wr_o
);

  // framing state, kept between words
  logic                   in_pkt_q;
  logic                   tlp_q;
  // up to four bytes of the open packet not yet sent
  // four are kept so that the last beat can still get tlast
  logic [3:0][7:0]        left_q;
  logic [2:0]             left_cnt_q;
  // second beat owed by the previous word
  rx_phy_pkg::axis_beat_t pend_q;
  logic                   pend_vld_q;
  // reads issued but not yet seen at dec_i
  logic [1:0]             out_cnt_q;
  logic                   rd_q;

  // working values for the word at dec_i
  logic [7:0][7:0]        acc;
  logic [3:0]             acc_cnt;
  logic                   open_pkt;
  logic                   open_tlp;
  logic                   closing;
  logic                   nullify;
  rx_phy_pkg::byte_class_e cls;
  rx_phy_pkg::axis_beat_t beats [2];
  logic [1:0]             n_beats;
  logic [2:0]             need_slots;

  // build a beat from n low bytes
  function automatic rx_phy_pkg::axis_beat_t make_beat(
    input logic [31:0] bytes,
    input logic [2:0]  n,
    input logic        last,
    input logic        is_tlp,
    input logic        nul
  );
    rx_phy_pkg::axis_beat_t b;
    b.tdata           = bytes;
    b.tkeep           = 4'hF >> (3'd4 - n);
    b.tlast           = last;
    b.tuser.tlp       = is_tlp;
    b.tuser.nullified = nul & last;
    return b;
  endfunction

  // walk the word byte by byte
  always_comb begin
    acc      = '0;
    acc[3:0] = left_q;
    acc_cnt  = {1'b0, left_cnt_q};
    open_pkt = in_pkt_q;
    open_tlp = tlp_q;
    closing  = 1'b0;
    nullify  = 1'b0;
    cls      = rx_phy_pkg::data;
    n_beats  = '0;
    beats[0] = '0;
    beats[1] = '0;
    for (int i = 0; i < rx_phy_pkg::lane_bytes; i++) begin
      cls = dec_i.byte_cls[i];
      // payload only counts inside a packet
      if (cls == rx_phy_pkg::data && open_pkt) begin
        acc[acc_cnt[2:0]] = dec_i.byte_data[i];
        acc_cnt           = acc_cnt + 4'd1;
      end
      // any end or start closes an open packet
      closing = open_pkt && cls != rx_phy_pkg::data && cls != rx_phy_pkg::other_k;
      if (closing) begin
        // only a clean END keeps the packet good
        nullify = (cls != rx_phy_pkg::end_good);
        if (acc_cnt > 4'd4) begin
          beats[0] = make_beat(acc[3:0], 3'd4, 1'b0, open_tlp, 1'b0);
          beats[1] = make_beat(acc[7:4], 3'(acc_cnt - 4'd4), 1'b1, open_tlp, nullify);
          n_beats  = 2'd2;
        end else if (acc_cnt != 4'd0) begin
          // zero length packets send nothing
          if (n_beats < 2'd2) begin
            beats[n_beats[0]] = make_beat(acc[3:0], acc_cnt[2:0], 1'b1, open_tlp, nullify);
          end
          n_beats = n_beats + 2'd1;
        end
        open_pkt = 1'b0;
        acc      = '0;
        acc_cnt  = '0;
      end
      // start symbol opens a fresh accumulator
      if (cls == rx_phy_pkg::stp || cls == rx_phy_pkg::sdp) begin
        open_pkt = 1'b1;
        open_tlp = (cls == rx_phy_pkg::stp);
        acc      = '0;
        acc_cnt  = '0;
      end
    end
    // more than four held, so the first four are surely not last
    if (acc_cnt > 4'd4) begin
      if (n_beats < 2'd2) begin
        beats[n_beats[0]] = make_beat(acc[3:0], 3'd4, 1'b0, open_tlp, 1'b0);
      end
      n_beats = n_beats + 2'd1;
      acc     = acc >> 32;
      acc_cnt = acc_cnt - 4'd4;
    end
  end

  // read pacing
  // two slots per outstanding word, two for the new one, one for a pending beat
  assign need_slots = {out_cnt_q, 1'b0} + 3'd2 + {2'b00, pend_vld_q};
  // never in back to back cycles, so every word gets two write slots
  assign phy_fifo_rd_en_o = phy_link_up_i && !phy_fifo_empty_i && !rd_q &&
                            (free_slots_i >= {1'b0, need_slots});

  // pending beat goes first, it never meets a new word
  assign beat_wr_o = pend_vld_q || (dec_i.valid && n_beats != 2'd0);
  assign beat_o    = pend_vld_q ? pend_q : beats[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_pkt_q   <= 1'b0;
      tlp_q      <= 1'b0;
      left_cnt_q <= '0;
      pend_vld_q <= 1'b0;
      out_cnt_q  <= '0;
      rd_q       <= 1'b0;
    end else begin
      rd_q       <= phy_fifo_rd_en_o;
      out_cnt_q  <= out_cnt_q + {1'b0, phy_fifo_rd_en_o} - {1'b0, dec_i.valid};
      pend_vld_q <= dec_i.valid && n_beats >= 2'd2;
      if (dec_i.valid) begin
        in_pkt_q   <= open_pkt;
        tlp_q      <= open_tlp;
        left_cnt_q <= acc_cnt[2:0];
      end
    end
    // payload only
    if (dec_i.valid) begin
      left_q <= acc[3:0];
      pend_q <= beats[1];
    end
  end

endmodule

`default_nettype wire

// File: verilog/rx_axis_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rx_axis_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wr_i,
  input  rx_phy_pkg::axis_beat_t beat_i,
  input  logic                   m_axis_tready_i,
  output logic [3:0]             free_slots_o,
  output rx_phy_pkg::axis_beat_t m_axis_beat_o,
  output logic                   m_axis_tvalid_o
);

  localparam int addr_w = $clog2(fifo_depth);
  // one extra bit so a full FIFO can be counted
  localparam int cnt_w = addr_w + 1;

  rx_phy_pkg::axis_beat_t mem [fifo_depth];
  logic [addr_w-1:0]      wr_ptr_q;
  logic [addr_w-1:0]      rd_ptr_q;
  logic [cnt_w-1:0]       count_q;
  logic [cnt_w-1:0]       free;
  logic                   push;
  logic                   pop;

  // head beat leaves on valid and ready
  assign pop  = m_axis_tvalid_o && m_axis_tready_i;
  // a write to a full FIFO is dropped
  assign push = wr_i && (count_q != cnt_w'(fifo_depth));

  assign free = cnt_w'(fifo_depth) - count_q;
  // deeper FIFOs report at most fifteen free
  assign free_slots_o = (int'(free) > 15) ? 4'd15 : 4'(free);

  // head is shown straight from the array
  assign m_axis_tvalid_o = (count_q != '0);
  assign m_axis_beat_o   = mem[rd_ptr_q];

  // pointers and occupancy
  // power of two depth lets the pointers wrap by themselves
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + addr_w'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + addr_w'(1);
      end
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= beat_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rx_data_handler.sv
`timescale 1ns/1ns
`default_nettype none

module rx_data_handler #(
  parameter int fifo_depth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // PHY elastic FIFO side
  input  logic                  phy_link_up_i,
  input  logic                  phy_fifo_empty_i,
  output logic                  phy_fifo_rd_en_o,
  input  logic                  data_valid_i,
  input  logic [31:0]           data_i,
  input  logic [3:0]            data_k_i,
  // AXI-stream master
  output logic [31:0]           m_axis_tdata_o,
  output logic [3:0]            m_axis_tkeep_o,
  output logic                  m_axis_tvalid_o,
  output logic                  m_axis_tlast_o,
  output rx_phy_pkg::pkt_user_t m_axis_tuser_o,
  input  logic                  m_axis_tready_i
);

  // decoded word into the framer
  rx_phy_pkg::dec_beat_t  dec;
  // framer beats into the FIFO
  rx_phy_pkg::axis_beat_t beat;
  logic                   beat_wr;
  logic [3:0]             free_slots;
  // FIFO head
  rx_phy_pkg::axis_beat_t head;

  rx_symbol_decode i_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_k_i     (data_k_i),
    .dec_o        (dec)
  );

  rx_frame_align i_align (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .phy_link_up_i    (phy_link_up_i),
    .phy_fifo_empty_i (phy_fifo_empty_i),
    .dec_i            (dec),
    .free_slots_i     (free_slots),
    .phy_fifo_rd_en_o (phy_fifo_rd_en_o),
    .beat_o           (beat),
    .beat_wr_o        (beat_wr)
  );

  rx_axis_fifo #(
    .fifo_depth (fifo_depth)
  ) i_fifo (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wr_i            (beat_wr),
    .beat_i          (beat),
    .m_axis_tready_i (m_axis_tready_i),
    .free_slots_o    (free_slots),
    .m_axis_beat_o   (head),
    .m_axis_tvalid_o (m_axis_tvalid_o)
  );

  // unpack the head beat onto the ports
  assign m_axis_tdata_o = head.tdata;
  assign m_axis_tkeep_o = head.tkeep;
  assign m_axis_tlast_o = head.tlast;
  assign m_axis_tuser_o = head.tuser;

endmodule

`default_nettype wire

// File: dv/rx_data_handler_sva.sv
`timescale 1ns/1ns
`default_nettype none

module rx_data_handler_sva (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  phy_link_up_i,
  input logic                  phy_fifo_empty_i,
  input logic                  phy_fifo_rd_en_o,
  input logic [31:0]           m_axis_tdata_o,
  input logic [3:0]            m_axis_tkeep_o,
  input logic                  m_axis_tvalid_o,
  input logic                  m_axis_tlast_o,
  input rx_phy_pkg::pkt_user_t m_axis_tuser_o,
  input logic                  m_axis_tready_i
);

  // reads only from a live, non-empty FIFO
  rd_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    phy_fifo_rd_en_o |-> (phy_link_up_i && !phy_fifo_empty_i))
    else $error("read strobe while PHY FIFO empty or link down");

  // stalled beat keeps valid and all its fields
  stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_axis_tvalid_o && !m_axis_tready_i) |=> (m_axis_tvalid_o &&
    $stable({m_axis_tdata_o, m_axis_tkeep_o, m_axis_tlast_o, m_axis_tuser_o})))
    else $error("stalled output beat changed or dropped valid");

endmodule

bind rx_data_handler rx_data_handler_sva i_sva (.*);

`default_nettype wire

// File: dv/tb_packet_table.svh
`ifndef TB_PACKET_TABLE_SVH
`define TB_PACKET_TABLE_SVH

// columns: name, is_tlp, payload len, edb end, lead idle bytes, next start in same word
localparam int num_tests = 25;

localparam pkt_desc_t test_rows [num_tests] = '{
  // dllp, 6 bytes, every lead offset
  '{"dllp6_lead0", 1'b0, 4'd6, 1'b0, 2'd0, 1'b0},
  '{"dllp6_lead1", 1'b0, 4'd6, 1'b0, 2'd1, 1'b0},
  '{"dllp6_lead2", 1'b0, 4'd6, 1'b0, 2'd2, 1'b0},
  '{"dllp6_lead3", 1'b0, 4'd6, 1'b0, 2'd3, 1'b0},
  // tlp length sweep
  '{"tlp_len1", 1'b1, 4'd1, 1'b0, 2'd0, 1'b0},
  '{"tlp_len2", 1'b1, 4'd2, 1'b0, 2'd1, 1'b0},
  '{"tlp_len3", 1'b1, 4'd3, 1'b0, 2'd2, 1'b0},
  '{"tlp_len4", 1'b1, 4'd4, 1'b0, 2'd3, 1'b0},
  '{"tlp_len5", 1'b1, 4'd5, 1'b0, 2'd0, 1'b0},
  '{"tlp_len6", 1'b1, 4'd6, 1'b0, 2'd1, 1'b0},
  '{"tlp_len7", 1'b1, 4'd7, 1'b0, 2'd2, 1'b0},
  '{"tlp_len8", 1'b1, 4'd8, 1'b0, 2'd3, 1'b0},
  '{"tlp_len9", 1'b1, 4'd9, 1'b0, 2'd0, 1'b0},
  '{"tlp_len10", 1'b1, 4'd10, 1'b0, 2'd1, 1'b0},
  '{"tlp_len11", 1'b1, 4'd11, 1'b0, 2'd2, 1'b0},
  '{"tlp_len12", 1'b1, 4'd12, 1'b0, 2'd3, 1'b0},
  // nullified packets, framing codes as plain data
  '{"tlp5_edb", 1'b1, 4'd5, 1'b1, 2'd1, 1'b0},
  '{"dllp3_edb", 1'b0, 4'd3, 1'b1, 2'd0, 1'b0},
  '{"tlp8_edb", 1'b1, 4'd8, 1'b1, 2'd2, 1'b0},
  // back to back, end and next start share a word
  '{"b2b_tlp4", 1'b1, 4'd4, 1'b0, 2'd2, 1'b1},
  '{"b2b_dllp2", 1'b0, 4'd2, 1'b0, 2'd0, 1'b1},
  '{"b2b_tlp0", 1'b1, 4'd0, 1'b0, 2'd0, 1'b1},
  '{"b2b_tlp7", 1'b1, 4'd7, 1'b0, 2'd0, 1'b1},
  '{"b2b_tlp9_edb", 1'b1, 4'd9, 1'b1, 2'd0, 1'b0},
  '{"dllp0_alone", 1'b0, 4'd0, 1'b0, 2'd1, 1'b0}
};

`endif

// File: dv/tb_rx_data_handler.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rx_data_handler;

  typedef struct packed {
    logic [127:0] name;
    logic         is_tlp;
    logic [3:0]   len;
    logic         edb;
    logic [1:0]   lead;
    logic         same_word;
  } pkt_desc_t;

  typedef struct packed {
    rx_phy_pkg::axis_beat_t beat;
    int                     test;
  } exp_beat_t;

  `include "tb_packet_table.svh"

  logic clk_i;
  logic rst_i;
  logic phy_link_up_i;
  logic phy_fifo_empty_i;
  logic data_valid_i;
  logic m_axis_tready_i;
  logic [31:0] data_i;
  logic [3:0] data_k_i;
  logic phy_fifo_rd_en_o;
  logic m_axis_tvalid_o;
  logic m_axis_tlast_o;
  logic [31:0] m_axis_tdata_o;
  logic [3:0] m_axis_tkeep_o;
  rx_phy_pkg::pkt_user_t m_axis_tuser_o;

  // PHY FIFO model contents and scoreboard
  logic [31:0] word_q [$];
  logic [3:0]  k_q [$];
  logic [7:0]  byte_q [$];
  logic        kb_q [$];
  exp_beat_t   exp_q [$];
  int exp_cnt [num_tests];
  int got_cnt [num_tests];
  int err_cnt [num_tests];
  int errors;
  int passed;
  logic rd_seen;
  logic gaps_on;
  logic timed_out;

  rx_data_handler #(.fifo_depth(8)) i_dut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // the model answers one cycle after the strobe
  always @(posedge clk_i) begin
    rd_seen <= rst_i ? 1'b0 : phy_fifo_rd_en_o;
  end

  // PHY side and tready change on the falling edge
  always @(negedge clk_i) begin
    data_valid_i = 1'b0;
    if (rd_seen) begin
      assert (word_q.size() > 0) else begin
        $display("read strobe with no word left in the PHY FIFO model");
        errors++;
      end
      if (word_q.size() > 0) begin
        data_i       = word_q.pop_front();
        data_k_i     = k_q.pop_front();
        data_valid_i = 1'b1;
      end
    end
    // random empty gaps
    phy_fifo_empty_i = (word_q.size() == 0) || (gaps_on && $urandom_range(3) == 0);
    m_axis_tready_i  = gaps_on ? ($urandom_range(2) != 0) : 1'b1;
  end

  function automatic logic [31:0] keep_mask(input logic [3:0] keep);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{keep[i]}};
    end
    return m;
  endfunction

  // scoreboard on each transfer
  always @(posedge clk_i) begin
    exp_beat_t e;
    logic [38:0] act;
    logic [38:0] exp;
    if (!rst_i && m_axis_tvalid_o && m_axis_tready_i) begin
      assert (exp_q.size() > 0) else begin
        $display("output beat %h arrived with no beat expected", m_axis_tdata_o);
        errors++;
      end
      if (exp_q.size() > 0) begin
        e   = exp_q.pop_front();
        exp = e.beat;
        act = {m_axis_tdata_o & keep_mask(m_axis_tkeep_o), m_axis_tkeep_o,
               m_axis_tlast_o, m_axis_tuser_o};
        got_cnt[e.test]++;
        assert (act == exp) else begin
          $display("Fail %0s: expected %h, actual %h", test_rows[e.test].name, exp, act);
          errors++;
          err_cnt[e.test]++;
        end
      end
    end
  end

  // byte stream and expected beats for every row
  task automatic build_stream();
    int lead;
    logic prev_same;
    logic [7:0] pay [12];
    exp_beat_t e;
    int n;
    prev_same = 1'b0;
    for (int r = 0; r < num_tests; r++) begin
      lead = prev_same ? 0 : int'(test_rows[r].lead);
      // keep the end off byte 3 so the next start shares its word
      if (test_rows[r].same_word && !prev_same &&
          (byte_q.size() + lead + 1 + int'(test_rows[r].len)) % 4 == 3) begin
        lead++;
      end
      repeat (lead) begin
        byte_q.push_back(8'($urandom_range(255)));
        kb_q.push_back(1'b0);
      end
      byte_q.push_back(test_rows[r].is_tlp ? rx_phy_pkg::sym_stp : rx_phy_pkg::sym_sdp);
      kb_q.push_back(1'b1);
      for (int i = 0; i < int'(test_rows[r].len); i++) begin
        pay[i] = 8'($urandom_range(255));
        // framing codes without K are plain payload
        if (test_rows[r].edb && i == 0) pay[i] = rx_phy_pkg::sym_stp;
        if (test_rows[r].edb && i == 1) pay[i] = rx_phy_pkg::sym_end;
        byte_q.push_back(pay[i]);
        kb_q.push_back(1'b0);
      end
      byte_q.push_back(test_rows[r].edb ? rx_phy_pkg::sym_edb : rx_phy_pkg::sym_end);
      kb_q.push_back(1'b1);
      // four bytes per beat with low aligned keep on the last
      for (int i = 0; i < int'(test_rows[r].len); i += 4) begin
        n = (int'(test_rows[r].len) - i > 4) ? 4 : int'(test_rows[r].len) - i;
        e = '0;
        for (int j = 0; j < n; j++) begin
          e.beat.tdata[8*j +: 8] = pay[i+j];
        end
        e.beat.tkeep           = 4'((1 << n) - 1);
        e.beat.tlast           = (i + 4 >= int'(test_rows[r].len));
        e.beat.tuser.tlp       = test_rows[r].is_tlp;
        e.beat.tuser.nullified = test_rows[r].edb && e.beat.tlast;
        e.test                 = r;
        exp_q.push_back(e);
        exp_cnt[r]++;
      end
      while (!test_rows[r].same_word && byte_q.size() % 4 != 0) begin
        byte_q.push_back(8'($urandom_range(255)));
        kb_q.push_back(1'b0);
      end
      prev_same = test_rows[r].same_word;
    end
    while (byte_q.size() % 4 != 0) begin
      byte_q.push_back(8'h00);
      kb_q.push_back(1'b0);
    end
    // low byte first on the wire
    while (byte_q.size() > 0) begin
      word_q.push_back({byte_q[3], byte_q[2], byte_q[1], byte_q[0]});
      k_q.push_back({kb_q[3], kb_q[2], kb_q[1], kb_q[0]});
      repeat (4) begin
        void'(byte_q.pop_front());
        void'(kb_q.pop_front());
      end
    end
  endtask

  initial begin
    int waited;
    phy_link_up_i = 1'b0;
    phy_fifo_empty_i = 1'b1;
    data_valid_i = 1'b0;
    data_i = '0;
    data_k_i = '0;
    m_axis_tready_i = 1'b0;
    gaps_on = 1'b0;
    timed_out = 1'b0;
    errors = 0;
    passed = 0;
    void'($urandom(32'h47a6_3452));
    rst_i = 1'b1;
    build_stream();
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    phy_link_up_i = 1'b1;
    gaps_on = 1'b1;
    for (int t = 0; t < num_tests && !timed_out; t++) begin
      waited = 0;
      while (got_cnt[t] < exp_cnt[t] && waited < 4000) begin
        @(negedge clk_i);
        waited++;
      end
      if (got_cnt[t] < exp_cnt[t]) begin
        $display("timeout, test %0s still waits for %0d output beats",
                 test_rows[t].name, exp_cnt[t] - got_cnt[t]);
        errors++;
        timed_out = 1'b1;
      end else begin
        if (err_cnt[t] == 0) passed++;
        $display("test %0s: %0d beats, %0s", test_rows[t].name, exp_cnt[t],
                 (err_cnt[t] == 0) ? "ok" : "mismatch");
      end
    end
    // trailing zero length rows must be read before the link drops
    waited = 0;
    while (word_q.size() > 0 && waited < 400) begin
      @(negedge clk_i);
      waited++;
    end
    if (word_q.size() > 0) begin
      $display("timeout, PHY FIFO model still holds %0d words", word_q.size());
      errors++;
      timed_out = 1'b1;
    end
    // with the link down a waiting word must stay put
    @(negedge clk_i);
    phy_link_up_i = 1'b0;
    word_q.push_back({8'h11, 8'h22, 8'h33, rx_phy_pkg::sym_stp});
    k_q.push_back(4'b0001);
    repeat (40) begin
      @(posedge clk_i);
      assert (!phy_fifo_rd_en_o && !m_axis_tvalid_o) else begin
        $display("read strobe or output beat seen while the link is down");
        errors++;
      end
    end
    $display("test link_down: done");
    $display("tests %0d, passed %0d, errors %0d", num_tests, passed, errors);
    if (errors == 0 && !timed_out && exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+dv
verilog/rx_phy_pkg.sv
verilog/rx_symbol_decode.sv
verilog/rx_frame_align.sv
verilog/rx_axis_fifo.sv
verilog/rx_data_handler.sv
dv/rx_data_handler_sva.sv
dv/tb_rx_data_handler.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rx_data_handler
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@! grep -q "TEST RESULT: FAIL" $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
